//--- src/ndn_pkt_pkg.sv
`default_nettype none

// Packet format shared by the MCU link and the network ingress
package ndn_pkt_pkg;

    // Field widths in bits
    localparam int PREFIX_W = 64;
    localparam int PLEN_W   = 6;
    localparam int BYTE_W   = 8;

    // Byte counts of a network data packet
    localparam int PREFIX_BYTES  = PREFIX_W / BYTE_W;
    localparam int PAYLOAD_BYTES = 32;

    // Derived sizes of the serial data frame
    localparam int PAYLOAD_BITS = PAYLOAD_BYTES * BYTE_W;
    localparam int FRAME_BITS   = PREFIX_W + PAYLOAD_BITS;

    // Content name, MSB is the first name bit
    typedef logic [PREFIX_W-1:0] prefix_t;

    // Significant prefix bits, 0 stands for the full name
    typedef logic [PLEN_W-1:0] plen_t;

    // One payload or name byte
    typedef logic [BYTE_W-1:0] byte_t;

endpackage

`default_nettype wire

//--- src/ndn_pit_pkg.sv
`default_nettype none

// Pending interest table sizing
package ndn_pit_pkg;

    // Entries in the table unless the top level overrides it
    localparam int PIT_DEPTH_DEFAULT = 8;

    // Index into a table of the default depth
    // A table of another depth derives its own index width
    typedef logic [$clog2(PIT_DEPTH_DEFAULT)-1:0] pit_idx_t;

endpackage

`default_nettype wire

//--- src/pit_lookup_if.sv
`timescale 1ns/10ps
`default_nettype none

// Name lookup between the data ingress and the pending table
interface pit_lookup_if;

    // One-cycle lookup request with the data name
    logic                  req;
    ndn_pkt_pkg::prefix_t  prefix;

    // Registered answer where exactly one pulses the cycle after req
    logic                  hit;
    logic                  miss;

    // Requesting side
    modport ingress (
        output req,
        output prefix,
        input  hit,
        input  miss
    );

    // Answering side
    modport tbl (
        input  req,
        input  prefix,
        output hit,
        output miss
    );

endinterface

`default_nettype wire

//--- src/mcu_link.sv
`timescale 1ns/10ps
`default_nettype none

// Serial link to the MCU, one bit per clk, lines idle high
module mcu_link (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  mosi,
    input  wire logic                  dlv_start,
    input  wire ndn_pkt_pkg::prefix_t  dlv_prefix,
    input  wire ndn_pkt_pkg::byte_t    dlv_byte,
    output logic                       miso,
    output logic                       interest_valid,
    output ndn_pkt_pkg::plen_t         interest_len,
    output ndn_pkt_pkg::prefix_t       interest_prefix,
    output logic                       tx_busy
);

    localparam int PLEN_W       = ndn_pkt_pkg::PLEN_W;
    localparam int PREFIX_W     = ndn_pkt_pkg::PREFIX_W;
    localparam int BYTE_W       = ndn_pkt_pkg::BYTE_W;
    localparam int PAYLOAD_BITS = ndn_pkt_pkg::PAYLOAD_BITS;
    localparam int FRAME_BITS   = ndn_pkt_pkg::FRAME_BITS;

    typedef enum logic [1:0] {RX_IDLE, RX_LEN, RX_PREFIX} rx_state_t;
    typedef enum logic [1:0] {TX_IDLE, TX_LOAD, TX_SEND} tx_state_t;

    rx_state_t rx_state;
    logic [6:0] rx_cnt;

    tx_state_t tx_state;
    logic [8:0] tx_cnt;
    // Name in the upper bits, payload below, MSB goes out first
    logic [FRAME_BITS-1:0] tx_sh;

    // Receiver FSM
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_state <= RX_IDLE;
            rx_cnt <= '0;
            interest_valid <= 1'b0;
        end else begin
            // Strobe lasts one cycle
            interest_valid <= 1'b0;
            case (rx_state)
                RX_IDLE: begin
                    rx_cnt <= '0;
                    // Low level on an idle line is the start bit
                    if (!mosi) begin
                        rx_state <= RX_LEN;
                    end
                end
                RX_LEN: begin
                    if (rx_cnt == 7'(PLEN_W - 1)) begin
                        rx_cnt <= '0;
                        rx_state <= RX_PREFIX;
                    end else begin
                        rx_cnt <= rx_cnt + 7'd1;
                    end
                end
                RX_PREFIX: begin
                    if (rx_cnt == 7'(PREFIX_W - 1)) begin
                        // Back in idle already in the strobe cycle
                        interest_valid <= 1'b1;
                        rx_state <= RX_IDLE;
                    end
                    rx_cnt <= rx_cnt + 7'd1;
                end
                default: rx_state <= RX_IDLE;
            endcase
        end
    end

    // Length and name shift in MSB first
    // They hold until the next frame reaches the same field
    always_ff @(posedge clk) begin
        if (rx_state == RX_LEN) begin
            interest_len <= {interest_len[PLEN_W-2:0], mosi};
        end
        if (rx_state == RX_PREFIX) begin
            interest_prefix <= {interest_prefix[PREFIX_W-2:0], mosi};
        end
    end

    // Transmitter FSM
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx_state <= TX_IDLE;
            tx_cnt <= '0;
            miso <= 1'b1;
        end else begin
            case (tx_state)
                TX_IDLE: begin
                    tx_cnt <= '0;
                    miso <= 1'b1;
                    if (dlv_start) begin
                        tx_state <= TX_LOAD;
                    end
                end
                TX_LOAD: begin
                    // One payload byte per cycle, start bit after the last
                    if (tx_cnt == 9'(ndn_pkt_pkg::PAYLOAD_BYTES - 1)) begin
                        tx_cnt <= '0;
                        miso <= 1'b0;
                        tx_state <= TX_SEND;
                    end else begin
                        tx_cnt <= tx_cnt + 9'd1;
                    end
                end
                TX_SEND: begin
                    if (tx_cnt == 9'(FRAME_BITS)) begin
                        // Release the line and the busy level together
                        miso <= 1'b1;
                        tx_state <= TX_IDLE;
                    end else begin
                        miso <= tx_sh[FRAME_BITS-1];
                        tx_cnt <= tx_cnt + 9'd1;
                    end
                end
                default: tx_state <= TX_IDLE;
            endcase
        end
    end

    // Frame shift register
    always_ff @(posedge clk) begin
        case (tx_state)
            TX_IDLE: begin
                if (dlv_start) begin
                    tx_sh[FRAME_BITS-1 -: PREFIX_W] <= dlv_prefix;
                end
            end
            TX_LOAD: begin
                tx_sh[PAYLOAD_BITS-1:0] <= {tx_sh[PAYLOAD_BITS-BYTE_W-1:0], dlv_byte};
            end
            TX_SEND: begin
                tx_sh <= tx_sh << 1;
            end
            default: ;
        endcase
    end

    // Busy from the first load cycle until the line is released
    assign tx_busy = (tx_state != TX_IDLE);

endmodule

`default_nettype wire

//--- src/pit_table.sv
`timescale 1ns/10ps
`default_nettype none

// Pending interest table with masked name match
module pit_table #(
    parameter int PIT_DEPTH = ndn_pit_pkg::PIT_DEPTH_DEFAULT
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  interest_valid,
    input  wire ndn_pkt_pkg::plen_t    interest_len,
    input  wire ndn_pkt_pkg::prefix_t  interest_prefix,
    output logic                       pit_full,
    pit_lookup_if.tbl                  lookup
);

    localparam int IDX_W = $clog2(PIT_DEPTH);
    localparam ndn_pkt_pkg::prefix_t ALL_ONES = '1;

    // Entry storage
    logic [PIT_DEPTH-1:0] ent_valid;
    ndn_pkt_pkg::plen_t   ent_len [PIT_DEPTH];
    ndn_pkt_pkg::prefix_t ent_pfx [PIT_DEPTH];

    // Per-entry compare results
    ndn_pkt_pkg::prefix_t ent_mask [PIT_DEPTH];
    logic [PIT_DEPTH-1:0] match;
    logic [PIT_DEPTH-1:0] dup;

    // Priority picks
    logic                 hit_found;
    logic [IDX_W-1:0]     hit_idx;
    logic                 free_found;
    logic [IDX_W-1:0]     free_idx;
    logic [PIT_DEPTH-1:0] valid_post;
    logic                 do_insert;

    for (genvar g = 0; g < PIT_DEPTH; g++) begin : g_cmp
        // Top N bits significant and a zero length keeps the whole name
        assign ent_mask[g] = (ent_len[g] == '0) ? ALL_ONES : ~(ALL_ONES >> ent_len[g]);
        assign match[g] = ent_valid[g] &&
                          (((ent_pfx[g] ^ lookup.prefix) & ent_mask[g]) == '0);
        // Duplicate test runs on the table after the lookup took its entry
        assign dup[g] = valid_post[g] && (ent_len[g] == interest_len) &&
                        (ent_pfx[g] == interest_prefix);
    end

    always_comb begin
        hit_found = 1'b0;
        hit_idx = '0;
        free_found = 1'b0;
        free_idx = '0;
        // Walk downward so the lowest index wins
        for (int i = PIT_DEPTH - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit_found = 1'b1;
                hit_idx = IDX_W'(i);
            end
        end
        valid_post = ent_valid;
        if (lookup.req && hit_found) begin
            valid_post[hit_idx] = 1'b0;
        end
        for (int i = PIT_DEPTH - 1; i >= 0; i--) begin
            if (!valid_post[i]) begin
                free_found = 1'b1;
                free_idx = IDX_W'(i);
            end
        end
        // Aggregated or dropped when full
        do_insert = interest_valid && !(|dup) && free_found;
    end

    // Valid bits and the lookup answer
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ent_valid <= '0;
            lookup.hit <= 1'b0;
            lookup.miss <= 1'b0;
        end else begin
            lookup.hit <= lookup.req && hit_found;
            lookup.miss <= lookup.req && !hit_found;
            ent_valid <= valid_post;
            if (do_insert) begin
                ent_valid[free_idx] <= 1'b1;
            end
        end
    end

    // Name and length of a new entry
    always_ff @(posedge clk) begin
        if (do_insert) begin
            ent_len[free_idx] <= interest_len;
            ent_pfx[free_idx] <= interest_prefix;
        end
    end

    assign pit_full = &ent_valid;

endmodule

`default_nettype wire

//--- src/data_ingress.sv
`timescale 1ns/10ps
`default_nettype none

// Network data collection, table lookup and delivery to the link
module data_ingress (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 net_valid,
    input  wire logic                 net_sof,
    input  wire ndn_pkt_pkg::byte_t   net_byte,
    input  wire logic                 tx_busy,
    output logic                      net_busy,
    output logic                      net_drop,
    output logic                      dlv_start,
    output ndn_pkt_pkg::prefix_t      dlv_prefix,
    output ndn_pkt_pkg::byte_t        dlv_byte,
    pit_lookup_if.ingress             lookup
);

    localparam int BYTE_W       = ndn_pkt_pkg::BYTE_W;
    localparam int PAYLOAD_BITS = ndn_pkt_pkg::PAYLOAD_BITS;
    localparam int PKT_BYTES    = ndn_pkt_pkg::PREFIX_BYTES + ndn_pkt_pkg::PAYLOAD_BYTES;

    typedef enum logic [2:0] {ST_COLLECT, ST_REQ, ST_WAIT, ST_HOLD, ST_STREAM} state_t;

    state_t state;
    logic [5:0] byte_cnt;
    logic [5:0] byte_idx;
    logic       take;

    ndn_pkt_pkg::prefix_t    name;
    logic [PAYLOAD_BITS-1:0] payload;

    // SOF forces the byte back to position zero
    assign byte_idx = net_sof ? '0 : byte_cnt;
    assign take = net_valid && (state == ST_COLLECT);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_COLLECT;
            byte_cnt <= '0;
        end else begin
            case (state)
                ST_COLLECT: begin
                    if (take) begin
                        if (byte_idx == 6'(PKT_BYTES - 1)) begin
                            byte_cnt <= '0;
                            state <= ST_REQ;
                        end else begin
                            byte_cnt <= byte_idx + 6'd1;
                        end
                    end
                end
                ST_REQ: state <= ST_WAIT;
                ST_WAIT: begin
                    if (lookup.miss) begin
                        state <= ST_COLLECT;
                    end else if (lookup.hit) begin
                        state <= ST_HOLD;
                    end
                end
                // Leaves as soon as the link is free
                ST_HOLD: begin
                    if (!tx_busy) begin
                        state <= ST_STREAM;
                    end
                end
                ST_STREAM: begin
                    if (byte_cnt == 6'(ndn_pkt_pkg::PAYLOAD_BYTES - 1)) begin
                        byte_cnt <= '0;
                        state <= ST_COLLECT;
                    end else begin
                        byte_cnt <= byte_cnt + 6'd1;
                    end
                end
                default: state <= ST_COLLECT;
            endcase
        end
    end

    // Name bytes first, then payload, both shift in MSB first
    always_ff @(posedge clk) begin
        if (take && byte_idx < 6'(ndn_pkt_pkg::PREFIX_BYTES)) begin
            name <= {name[ndn_pkt_pkg::PREFIX_W-BYTE_W-1:0], net_byte};
        end else if (take) begin
            payload <= {payload[PAYLOAD_BITS-BYTE_W-1:0], net_byte};
        end else if (state == ST_STREAM) begin
            payload <= payload << BYTE_W;
        end
    end

    assign lookup.req = (state == ST_REQ);
    assign lookup.prefix = name;
    assign net_busy = (state != ST_COLLECT);
    assign net_drop = (state == ST_WAIT) && lookup.miss;
    assign dlv_start = (state == ST_HOLD) && !tx_busy;
    assign dlv_prefix = name;
    // Top byte of the buffer is the current delivery byte
    assign dlv_byte = payload[PAYLOAD_BITS-1 -: BYTE_W];

endmodule

`default_nettype wire

//--- src/ndn_mcu_top.sv
`timescale 1ns/10ps
`default_nettype none

// User-facing edge of the forwarder
module ndn_mcu_top #(
    parameter int PIT_DEPTH = ndn_pit_pkg::PIT_DEPTH_DEFAULT
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                mosi,
    input  wire logic                net_valid,
    input  wire logic                net_sof,
    input  wire ndn_pkt_pkg::byte_t  net_byte,
    output logic                     miso,
    output logic                     net_busy,
    output logic                     net_drop,
    output logic                     pit_full
);

    // Interest path
    logic                 interest_valid;
    ndn_pkt_pkg::plen_t   interest_len;
    ndn_pkt_pkg::prefix_t interest_prefix;

    // Delivery path
    logic                 dlv_start;
    ndn_pkt_pkg::prefix_t dlv_prefix;
    ndn_pkt_pkg::byte_t   dlv_byte;
    logic                 tx_busy;

    // Lookup path
    pit_lookup_if lookup_if ();

    mcu_link mcu_link_i (
        .clk             (clk),
        .rst             (rst),
        .mosi            (mosi),
        .dlv_start       (dlv_start),
        .dlv_prefix      (dlv_prefix),
        .dlv_byte        (dlv_byte),
        .miso            (miso),
        .interest_valid  (interest_valid),
        .interest_len    (interest_len),
        .interest_prefix (interest_prefix),
        .tx_busy         (tx_busy)
    );

    pit_table #(
        .PIT_DEPTH (PIT_DEPTH)
    ) pit_table_i (
        .clk             (clk),
        .rst             (rst),
        .interest_valid  (interest_valid),
        .interest_len    (interest_len),
        .interest_prefix (interest_prefix),
        .pit_full        (pit_full),
        .lookup          (lookup_if.tbl)
    );

    data_ingress data_ingress_i (
        .clk        (clk),
        .rst        (rst),
        .net_valid  (net_valid),
        .net_sof    (net_sof),
        .net_byte   (net_byte),
        .tx_busy    (tx_busy),
        .net_busy   (net_busy),
        .net_drop   (net_drop),
        .dlv_start  (dlv_start),
        .dlv_prefix (dlv_prefix),
        .dlv_byte   (dlv_byte),
        .lookup     (lookup_if.ingress)
    );

endmodule

`default_nettype wire

//--- sim/ndn_mcu_sva.sv
`timescale 1ns/10ps
`default_nettype none

// Lookup and delivery protocol checks bound into data_ingress and mcu_link
module ndn_mcu_sva (
    input wire logic clk,
    input wire logic rst,
    input wire logic req,
    input wire logic hit,
    input wire logic miss,
    input wire logic dlv_start,
    input wire logic tx_busy,
    input wire logic miso
);

    // Count of failed assertions for the testbench
    int fail_cnt = 0;

    // Never two answers at once
    a_answer_excl: assert property (@(posedge clk) disable iff (rst) !(hit && miss))
        else begin
            fail_cnt++;
            $error("hit and miss high in the same cycle");
        end

    // One answer in the cycle after each request
    a_answer_next: assert property (@(posedge clk) disable iff (rst) req |=> (hit ^ miss))
        else begin
            fail_cnt++;
            $error("lookup request without exactly one answer in the next cycle");
        end

    // Delivery only starts on a free link, which turns busy in the next cycle
    a_start_free: assert property (@(posedge clk) disable iff (rst)
                                   dlv_start |-> !tx_busy ##1 tx_busy)
        else begin
            fail_cnt++;
            $error("dlv_start while tx_busy is high or not taken up by the link");
        end

    // Idle link keeps miso high
    a_idle_high: assert property (@(posedge clk) disable iff (rst) !tx_busy |-> miso)
        else begin
            fail_cnt++;
            $error("miso low while tx_busy is low");
        end

endmodule

// Ingress side where miso is not visible
bind data_ingress ndn_mcu_sva data_ingress_sva_i (
    .clk       (clk),
    .rst       (rst),
    .req       (lookup.req),
    .hit       (lookup.hit),
    .miss      (lookup.miss),
    .dlv_start (dlv_start),
    .tx_busy   (tx_busy),
    .miso      (1'b1)
);

// Link side without the lookup bus
bind mcu_link ndn_mcu_sva mcu_link_sva_i (
    .clk       (clk),
    .rst       (rst),
    .req       (1'b0),
    .hit       (1'b0),
    .miss      (1'b0),
    .dlv_start (dlv_start),
    .tx_busy   (tx_busy),
    .miso      (miso)
);

`default_nettype wire

//--- sim/ndn_mcu_tb.sv
`timescale 1ns/10ps
`default_nettype none

// Testbench for the MCU edge of the forwarder
module ndn_mcu_tb;

    localparam int PIT_DEPTH  = ndn_pit_pkg::PIT_DEPTH_DEFAULT;
    localparam int CLK_PERIOD = 8;
    localparam int N_TESTS    = 8;
    localparam int DRAIN_MAX  = 1000;
    localparam int PAY_W      = ndn_pkt_pkg::PAYLOAD_BITS;
    localparam int FRAME_W    = ndn_pkt_pkg::FRAME_BITS;
    localparam int PKT_BYTES  = ndn_pkt_pkg::PREFIX_BYTES + ndn_pkt_pkg::PAYLOAD_BYTES;
    // Start bit, length and name
    localparam int IFRAME_W   = 1 + ndn_pkt_pkg::PLEN_W + ndn_pkt_pkg::PREFIX_W;

    logic               clk = 1'b0;
    logic               rst;
    logic               mosi;
    logic               net_valid;
    logic               net_sof;
    ndn_pkt_pkg::byte_t net_byte;
    logic               miso;
    logic               net_busy;
    logic               net_drop;
    logic               pit_full;

    // Model of the pending table
    logic                 ref_valid [PIT_DEPTH];
    ndn_pkt_pkg::plen_t   ref_len [PIT_DEPTH];
    ndn_pkt_pkg::prefix_t ref_pfx [PIT_DEPTH];

    // Predicted frames in delivery order, and predicted drops
    ndn_pkt_pkg::prefix_t exp_pfx_q [$];
    logic [PAY_W-1:0]     exp_pay_q [$];
    string                exp_name_q [$];
    string                drop_name_q [$];

    // Frames captured from miso
    ndn_pkt_pkg::prefix_t rx_pfx_q [$];
    logic [PAY_W-1:0]     rx_pay_q [$];

    int    errors = 0;
    string test_name;

    ndn_mcu_top #(
        .PIT_DEPTH (PIT_DEPTH)
    ) ndn_mcu_top_i (
        .clk       (clk),
        .rst       (rst),
        .mosi      (mosi),
        .net_valid (net_valid),
        .net_sof   (net_sof),
        .net_byte  (net_byte),
        .miso      (miso),
        .net_busy  (net_busy),
        .net_drop  (net_drop),
        .pit_full  (pit_full)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_failure(input string msg);
        errors++;
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_prefix(input string name, input ndn_pkt_pkg::prefix_t exp_v,
                                input ndn_pkt_pkg::prefix_t act_v);
        if (act_v !== exp_v) begin
            report_failure($sformatf("error %s: expected %h, actual %h", name, exp_v, act_v));
        end
    endtask

    task automatic check_byte(input string name, input ndn_pkt_pkg::byte_t exp_v,
                              input ndn_pkt_pkg::byte_t act_v);
        if (act_v !== exp_v) begin
            report_failure($sformatf("error %s: expected %h, actual %h", name, exp_v, act_v));
        end
    endtask

    task automatic check_flag(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            report_failure($sformatf("error %s: expected %b, actual %b", name, exp_v, act_v));
        end
    endtask

    // Inputs change a little after the rising edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // Top len bits equal where len 0 compares the whole name
    function automatic bit name_matches(input ndn_pkt_pkg::plen_t len,
                                        input ndn_pkt_pkg::prefix_t a,
                                        input ndn_pkt_pkg::prefix_t b);
        int n;
        n = (len == 0) ? ndn_pkt_pkg::PREFIX_W : int'(len);
        for (int i = 0; i < n; i++) begin
            if (a[ndn_pkt_pkg::PREFIX_W - 1 - i] != b[ndn_pkt_pkg::PREFIX_W - 1 - i]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // One interest or one data lookup against the model
    // A data lookup returns 1 on a hit and consumes the lowest matching entry
    // An interest returns 1 when stored or aggregated and 0 when the table is full
    function automatic bit ref_pit_apply(input bit is_data, input ndn_pkt_pkg::plen_t len,
                                         input ndn_pkt_pkg::prefix_t pfx);
        if (is_data) begin
            for (int i = 0; i < PIT_DEPTH; i++) begin
                if (ref_valid[i] && name_matches(ref_len[i], ref_pfx[i], pfx)) begin
                    ref_valid[i] = 1'b0;
                    return 1'b1;
                end
            end
            return 1'b0;
        end
        // Same length and name joins the existing entry
        for (int i = 0; i < PIT_DEPTH; i++) begin
            if (ref_valid[i] && ref_len[i] == len && ref_pfx[i] == pfx) begin
                return 1'b1;
            end
        end
        for (int i = 0; i < PIT_DEPTH; i++) begin
            if (!ref_valid[i]) begin
                ref_valid[i] = 1'b1;
                ref_len[i] = len;
                ref_pfx[i] = pfx;
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic logic model_full();
        for (int i = 0; i < PIT_DEPTH; i++) begin
            if (!ref_valid[i]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    function automatic ndn_pkt_pkg::prefix_t rand_name();
        return {$urandom(), $urandom()};
    endfunction

    function automatic logic [PAY_W-1:0] make_payload();
        logic [PAY_W-1:0] p;
        for (int i = 0; i < PAY_W / 32; i++) begin
            p[32*i +: 32] = $urandom();
        end
        return p;
    endfunction

    function automatic int sva_fail_count();
        return ndn_mcu_top_i.data_ingress_i.data_ingress_sva_i.fail_cnt +
               ndn_mcu_top_i.mcu_link_i.mcu_link_sva_i.fail_cnt;
    endfunction

    // Start bit, 6 length bits and 64 name bits sent MSB first
    task automatic send_interest(input ndn_pkt_pkg::plen_t len, input ndn_pkt_pkg::prefix_t pfx);
        logic [IFRAME_W-1:0] frame;
        frame = {1'b0, len, pfx};
        for (int i = IFRAME_W - 1; i >= 0; i--) begin
            tick();
            mosi = frame[i];
        end
        tick();
        mosi = 1'b1;
        void'(ref_pit_apply(1'b0, len, pfx));
    endtask

    // 8 name bytes then 32 payload bytes with random idle gaps
    task automatic send_data(input ndn_pkt_pkg::prefix_t pfx, input logic [PAY_W-1:0] pay);
        logic [PAY_W+ndn_pkt_pkg::PREFIX_W-1:0] pkt;
        pkt = {pfx, pay};
        if (ref_pit_apply(1'b1, '0, pfx)) begin
            exp_pfx_q.push_back(pfx);
            exp_pay_q.push_back(pay);
            exp_name_q.push_back(test_name);
        end else begin
            drop_name_q.push_back(test_name);
        end
        for (int i = 0; i < PKT_BYTES; i++) begin
            tick();
            net_valid = 1'b0;
            net_sof = 1'b0;
            if ($urandom_range(3) == 0) begin
                tick();
            end
            // Hold off while the previous packet is still in flight
            while (net_busy) begin
                tick();
            end
            net_valid = 1'b1;
            net_sof = (i == 0);
            net_byte = pkt[PAY_W + ndn_pkt_pkg::PREFIX_W - 1 - 8*i -: 8];
        end
        tick();
        net_valid = 1'b0;
        net_sof = 1'b0;
    endtask

    // Until every predicted frame and drop has been seen
    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_pfx_q.size() != 0 || drop_name_q.size() != 0) begin
            if (n == DRAIN_MAX) begin
                report_failure($sformatf("%s: %0d frames and %0d drops missing after %0d cycles",
                                         test_name, exp_pfx_q.size(), drop_name_q.size(), n));
            end
            tick();
            n++;
        end
    endtask

    // Start bit then 320 frame bits sampled mid-cycle
    initial begin : miso_monitor
        logic [FRAME_W-1:0] bits;
        forever begin
            @(negedge clk);
            if (miso === 1'b0) begin
                for (int i = 0; i < FRAME_W; i++) begin
                    @(negedge clk);
                    bits = {bits[FRAME_W-2:0], miso};
                end
                rx_pfx_q.push_back(bits[FRAME_W-1 -: ndn_pkt_pkg::PREFIX_W]);
                rx_pay_q.push_back(bits[PAY_W-1:0]);
            end
        end
    end

    initial begin : compare_proc
        ndn_pkt_pkg::prefix_t act_pfx;
        ndn_pkt_pkg::prefix_t exp_pfx;
        logic [PAY_W-1:0]     act_pay;
        logic [PAY_W-1:0]     exp_pay;
        string                name;
        logic                 drop_pending;
        forever begin
            @(negedge clk);
            if (sva_fail_count() != 0) begin
                report_failure("a bound protocol assertion failed");
            end
            if (net_drop === 1'b1) begin
                // A drop is right only when the model predicted one
                drop_pending = (drop_name_q.size() != 0);
                if (drop_pending) begin
                    name = drop_name_q.pop_front();
                end else begin
                    name = test_name;
                end
                check_flag({name, " drop"}, drop_pending, net_drop);
            end
            while (rx_pfx_q.size() > 0) begin
                act_pfx = rx_pfx_q.pop_front();
                act_pay = rx_pay_q.pop_front();
                if (exp_pfx_q.size() == 0) begin
                    report_failure("a frame appeared on miso that no pending interest asked for");
                end else begin
                    name = exp_name_q.pop_front();
                    exp_pfx = exp_pfx_q.pop_front();
                    exp_pay = exp_pay_q.pop_front();
                    check_prefix({name, " name"}, exp_pfx, act_pfx);
                    for (int k = 0; k < ndn_pkt_pkg::PAYLOAD_BYTES; k++) begin
                        check_byte($sformatf("%s byte %0d", name, k),
                                   exp_pay[PAY_W-1-8*k -: 8], act_pay[PAY_W-1-8*k -: 8]);
                    end
                end
            end
        end
    end

    // Budget of 800 cycles per test
    initial begin : watchdog
        #(N_TESTS * 800 * CLK_PERIOD);
        report_failure($sformatf("watchdog expired, %0d tests did not finish in time", N_TESTS));
    end

    initial begin : main_seq
        ndn_pkt_pkg::prefix_t a;
        ndn_pkt_pkg::prefix_t b;
        ndn_pkt_pkg::prefix_t extra;
        ndn_pkt_pkg::prefix_t names [PIT_DEPTH];
        void'($urandom(47558));
        rst = 1'b1;
        mosi = 1'b1;
        net_valid = 1'b0;
        net_sof = 1'b0;
        net_byte = '0;
        for (int i = 0; i < PIT_DEPTH; i++) begin
            ref_valid[i] = 1'b0;
        end
        test_name = "reset";
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        check_flag("reset miso", 1'b1, miso);
        check_flag("reset net_busy", 1'b0, net_busy);
        check_flag("reset net_drop", 1'b0, net_drop);
        check_flag("reset pit_full", 1'b0, pit_full);

        test_name = "full_match";
        a = rand_name();
        send_interest('0, a);
        send_data(a, make_payload());
        wait_drain();

        test_name = "no_match";
        send_data(rand_name(), make_payload());
        wait_drain();

        // Top bit differs first and then only bits below the top 12
        test_name = "short_prefix";
        a = rand_name();
        send_interest(6'd12, a);
        b = a ^ {1'b1, 63'd0};
        send_data(b, make_payload());
        b = a ^ ((rand_name() & {12'd0, {52{1'b1}}}) | 64'd1);
        send_data(b, make_payload());
        wait_drain();

        test_name = "consume";
        a = rand_name();
        send_interest('0, a);
        send_data(a, make_payload());
        send_data(a, make_payload());
        wait_drain();

        test_name = "aggregate";
        a = rand_name();
        send_interest('0, a);
        send_interest('0, a);
        send_data(a, make_payload());
        send_data(a, make_payload());
        wait_drain();

        // Fill every entry so one more interest is lost
        test_name = "table_full";
        for (int i = 0; i < PIT_DEPTH; i++) begin
            names[i] = rand_name();
            send_interest('0, names[i]);
            wait_cycles(2);
            check_flag("table_full pit_full", model_full(), pit_full);
        end
        extra = rand_name();
        send_interest('0, extra);
        wait_cycles(2);
        check_flag("table_full pit_full after extra", model_full(), pit_full);
        send_data(extra, make_payload());
        wait_drain();

        test_name = "table_release";
        send_data(names[0], make_payload());
        wait_drain();
        check_flag("table_release pit_full after hit", model_full(), pit_full);
        names[0] = rand_name();
        send_interest('0, names[0]);
        wait_cycles(2);
        check_flag("table_release pit_full after insert", model_full(), pit_full);

        // Later packets arrive while earlier frames are still on miso
        test_name = "back_to_back";
        for (int i = 1; i < 4; i++) begin
            send_data(names[i], make_payload());
        end
        wait_drain();

        // Quiet time so a stray frame would still be caught
        repeat (2 * FRAME_W) @(posedge clk);
        if (errors == 0 && sva_fail_count() == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
src/ndn_pkt_pkg.sv
src/ndn_pit_pkg.sv
src/pit_lookup_if.sv
src/mcu_link.sv
src/pit_table.sv
src/data_ingress.sv
src/ndn_mcu_top.sv
sim/ndn_mcu_sva.sv
sim/ndn_mcu_tb.sv
